/* verilog/burst_split_pkg.sv */
// Bus widths, AXI burst encodings and tracker sizing
// shared by the read-path burst splitter

package burst_split_pkg;

  // ------------------------------------------------------------
  // AXI field widths
  // ------------------------------------------------------------
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int ID_W    = 4;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  // Burst encodings, only FIXED and INCR are accepted upstream
  localparam logic [BURST_W-1:0] BURST_FIXED = 2'd0;
  localparam logic [BURST_W-1:0] BURST_INCR  = 2'd1;

  // ------------------------------------------------------------
  // Outstanding burst tracker
  // ------------------------------------------------------------
  // Number of bursts in flight at the same time
  localparam int MAX_TXNS = 4;

  // Entry index
  localparam int IDX_W = $clog2(MAX_TXNS);

  // Age rank among entries of one ID, 0 is the oldest
  localparam int RANK_W = 2;

endpackage

/* verilog/ar_splitter.sv */
// AR burst register and Idle/Busy FSM
// Turns each upstream burst into single-beat downstream reads
`timescale 1ns/100ps

module ar_splitter (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // Upstream AR
  input  logic                                 ar_valid_i,
  output logic                                 ar_ready_o,
  input  logic [burst_split_pkg::ID_W-1:0]     ar_id_i,
  input  logic [burst_split_pkg::ADDR_W-1:0]   ar_addr_i,
  input  logic [burst_split_pkg::LEN_W-1:0]    ar_len_i,
  input  logic [burst_split_pkg::SIZE_W-1:0]   ar_size_i,
  input  logic [burst_split_pkg::BURST_W-1:0]  ar_burst_i,
  // Downstream single-beat AR
  output logic                                 m_ar_valid_o,
  input  logic                                 m_ar_ready_i,
  output logic [burst_split_pkg::ID_W-1:0]     m_ar_id_o,
  output logic [burst_split_pkg::ADDR_W-1:0]   m_ar_addr_o,
  output logic [burst_split_pkg::SIZE_W-1:0]   m_ar_size_o,
  output logic [burst_split_pkg::BURST_W-1:0]  m_ar_burst_o,
  // Tracker allocation
  output logic                                 alloc_req_o,
  input  logic                                 alloc_gnt_i,
  output logic [burst_split_pkg::ID_W-1:0]     alloc_id_o,
  output logic [burst_split_pkg::LEN_W-1:0]    alloc_len_o
);

  logic                                busy_q, busy_d;
  logic [burst_split_pkg::ID_W-1:0]    id_q, id_d;
  logic [burst_split_pkg::ADDR_W-1:0]  addr_q, addr_d;
  logic [burst_split_pkg::LEN_W-1:0]   len_q, len_d;
  logic [burst_split_pkg::SIZE_W-1:0]  size_q, size_d;
  logic [burst_split_pkg::BURST_W-1:0] burst_q, burst_d;
  logic [burst_split_pkg::ADDR_W-1:0]  step_in, step_q;

  // INCR address step is 2^size bytes
  assign step_in = (burst_split_pkg::ADDR_W)'(1) << ar_size_i;
  assign step_q  = (burst_split_pkg::ADDR_W)'(1) << size_q;

  // Allocation always happens from Idle, so the input carries the burst
  assign alloc_id_o  = ar_id_i;
  assign alloc_len_o = ar_len_i;

  // ------------------------------------------------------------
  // Split FSM
  // ------------------------------------------------------------
  always_comb begin
    busy_d       = busy_q;
    id_d         = id_q;
    addr_d       = addr_q;
    len_d        = len_q;
    size_d       = size_q;
    burst_d      = burst_q;
    ar_ready_o   = 1'b0;
    alloc_req_o  = 1'b0;
    m_ar_valid_o = 1'b0;
    m_ar_id_o    = id_q;
    m_ar_addr_o  = addr_q;
    m_ar_size_o  = size_q;
    m_ar_burst_o = burst_q;

    if (!busy_q) begin
      // First beat goes straight from the input
      m_ar_id_o    = ar_id_i;
      m_ar_addr_o  = ar_addr_i;
      m_ar_size_o  = ar_size_i;
      m_ar_burst_o = ar_burst_i;
      if (ar_valid_i && alloc_gnt_i) begin
        m_ar_valid_o = 1'b1;
        if (ar_len_i == '0) begin
          // Single beat passes through and is taken with the downstream ready
          if (m_ar_ready_i) begin
            alloc_req_o = 1'b1;
            ar_ready_o  = 1'b1;
          end
        end else begin
          alloc_req_o = 1'b1;
          ar_ready_o  = 1'b1;
          busy_d      = 1'b1;
          id_d        = ar_id_i;
          size_d      = ar_size_i;
          burst_d     = ar_burst_i;
          addr_d      = ar_addr_i;
          len_d       = ar_len_i;
          // Registered beat moves past the first one once it is taken
          if (m_ar_ready_i) begin
            len_d = ar_len_i - (burst_split_pkg::LEN_W)'(1);
            if (ar_burst_i == burst_split_pkg::BURST_INCR) begin
              addr_d = ar_addr_i + step_in;
            end
          end
        end
      end
    end else begin
      m_ar_valid_o = 1'b1;
      if (m_ar_ready_i) begin
        if (len_q == '0) begin
          busy_d = 1'b0;
        end else begin
          len_d = len_q - (burst_split_pkg::LEN_W)'(1);
          if (burst_q == burst_split_pkg::BURST_INCR) begin
            addr_d = addr_q + step_q;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy_d;
    end
  end

  // Burst payload
  always_ff @(posedge clk_i) begin
    id_q    <= id_d;
    addr_q  <= addr_d;
    len_q   <= len_d;
    size_q  <= size_d;
    burst_q <= burst_d;
  end

endmodule

/* verilog/len_tracker.sv */
// Table of outstanding read bursts: ID, beats left and same-ID age rank
// Serves the remaining count of the oldest burst of an ID to the R path
`timescale 1ns/100ps

module len_tracker (
  input  logic                              clk_i,
  input  logic                              rst_i,
  // Allocation from the AR side
  input  logic                              alloc_req_i,
  output logic                              alloc_gnt_o,
  input  logic [burst_split_pkg::ID_W-1:0]  alloc_id_i,
  input  logic [burst_split_pkg::LEN_W-1:0] alloc_len_i,
  // Lookup and decrement from the R side
  input  logic [burst_split_pkg::ID_W-1:0]  rd_id_i,
  input  logic                              rd_dec_i,
  output logic                              r_gnt_o,
  output logic [burst_split_pkg::LEN_W-1:0] rem_len_o
);

  logic [burst_split_pkg::MAX_TXNS-1:0] valid_q;
  logic [burst_split_pkg::ID_W-1:0]     id_q   [burst_split_pkg::MAX_TXNS];
  logic [burst_split_pkg::LEN_W-1:0]    cnt_q  [burst_split_pkg::MAX_TXNS];
  logic [burst_split_pkg::RANK_W-1:0]   rank_q [burst_split_pkg::MAX_TXNS];

  logic [burst_split_pkg::IDX_W-1:0]    free_idx;
  logic [burst_split_pkg::IDX_W-1:0]    hit_idx;
  logic                                 hit;
  logic                                 alloc_fire;
  logic                                 dec_fire;
  logic                                 pop;
  logic [burst_split_pkg::RANK_W-1:0]   alloc_rank;

  // ------------------------------------------------------------
  // Free slot and ID lookup
  // ------------------------------------------------------------
  // Lowest free index wins
  always_comb begin
    free_idx = '0;
    for (int i = burst_split_pkg::MAX_TXNS - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = (burst_split_pkg::IDX_W)'(i);
      end
    end
  end

  // Oldest burst of the ID has rank zero, at most one entry matches
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = burst_split_pkg::MAX_TXNS - 1; i >= 0; i--) begin
      if (valid_q[i] && (id_q[i] == rd_id_i) && (rank_q[i] == '0)) begin
        hit     = 1'b1;
        hit_idx = (burst_split_pkg::IDX_W)'(i);
      end
    end
  end

  assign alloc_gnt_o = ~&valid_q;
  assign r_gnt_o     = hit;
  assign rem_len_o   = cnt_q[hit_idx];

  assign alloc_fire = alloc_req_i & alloc_gnt_o;
  assign dec_fire   = rd_dec_i & hit;
  assign pop        = dec_fire & (rem_len_o == '0);

  // New rank is the number of older bursts of the same ID still held,
  // not counting one that frees in this very cycle
  always_comb begin
    alloc_rank = '0;
    for (int i = 0; i < burst_split_pkg::MAX_TXNS; i++) begin
      if (valid_q[i] && (id_q[i] == alloc_id_i)) begin
        alloc_rank = alloc_rank + (burst_split_pkg::RANK_W)'(1);
      end
    end
    if (pop && (rd_id_i == alloc_id_i)) begin
      alloc_rank = alloc_rank - (burst_split_pkg::RANK_W)'(1);
    end
  end

  // ------------------------------------------------------------
  // Entry state
  // ------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      if (pop) begin
        valid_q[hit_idx] <= 1'b0;
      end
      if (alloc_fire) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < burst_split_pkg::MAX_TXNS; i++) begin
      if (alloc_fire && (free_idx == (burst_split_pkg::IDX_W)'(i))) begin
        id_q[i]   <= alloc_id_i;
        cnt_q[i]  <= alloc_len_i;
        rank_q[i] <= alloc_rank;
      end else begin
        if (dec_fire && !pop && (hit_idx == (burst_split_pkg::IDX_W)'(i))) begin
          cnt_q[i] <= cnt_q[i] - (burst_split_pkg::LEN_W)'(1);
        end
        // Younger bursts of the finished ID move up one place
        if (pop && valid_q[i] && (id_q[i] == rd_id_i) &&
            (hit_idx != (burst_split_pkg::IDX_W)'(i))) begin
          rank_q[i] <= rank_q[i] - (burst_split_pkg::RANK_W)'(1);
        end
      end
    end
  end

endmodule

/* verilog/r_last_gen.sv */
// R path Feed/Wait FSM
// Forwards single beats upstream and rebuilds last from the tracker
`timescale 1ns/100ps

module r_last_gen (
  input  logic                               clk_i,
  input  logic                               rst_i,
  // Downstream R
  input  logic                               m_r_valid_i,
  output logic                               m_r_ready_o,
  input  logic [burst_split_pkg::ID_W-1:0]   m_r_id_i,
  input  logic [burst_split_pkg::DATA_W-1:0] m_r_data_i,
  input  logic [burst_split_pkg::RESP_W-1:0] m_r_resp_i,
  // Upstream R
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output logic [burst_split_pkg::ID_W-1:0]   r_id_o,
  output logic [burst_split_pkg::DATA_W-1:0] r_data_o,
  output logic [burst_split_pkg::RESP_W-1:0] r_resp_o,
  output logic                               r_last_o,
  // Tracker lookup
  output logic [burst_split_pkg::ID_W-1:0]   rd_id_o,
  output logic                               rd_dec_o,
  input  logic                               r_gnt_i,
  input  logic [burst_split_pkg::LEN_W-1:0]  rem_len_i
);

  logic wait_q, wait_d;
  logic last_q, last_d;

  assign r_id_o   = m_r_id_i;
  assign r_data_o = m_r_data_i;
  assign r_resp_o = m_r_resp_i;
  assign rd_id_o  = m_r_id_i;

  always_comb begin
    wait_d      = wait_q;
    last_d      = last_q;
    r_valid_o   = 1'b0;
    r_last_o    = 1'b0;
    m_r_ready_o = 1'b0;
    rd_dec_o    = 1'b0;

    if (!wait_q) begin
      // Beat only goes up once the tracker knows its burst
      if (m_r_valid_i && r_gnt_i) begin
        r_valid_o = 1'b1;
        r_last_o  = (rem_len_i == '0);
        rd_dec_o  = 1'b1;
        if (r_ready_i) begin
          m_r_ready_o = 1'b1;
        end else begin
          // Entry is already counted down, keep last for the held beat
          wait_d = 1'b1;
          last_d = r_last_o;
        end
      end
    end else begin
      r_valid_o = m_r_valid_i;
      r_last_o  = last_q;
      if (m_r_valid_i && r_ready_i) begin
        m_r_ready_o = 1'b1;
        wait_d      = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= 1'b0;
      last_q <= 1'b0;
    end else begin
      wait_q <= wait_d;
      last_q <= last_d;
    end
  end

endmodule

/* verilog/burst_splitter_top.sv */
// Read-path AXI4 burst splitter top level
// AR splitter, outstanding burst tracker and R last rebuild
`timescale 1ns/100ps

module burst_splitter_top (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // Upstream AR
  input  logic                                 ar_valid_i,
  output logic                                 ar_ready_o,
  input  logic [burst_split_pkg::ID_W-1:0]     ar_id_i,
  input  logic [burst_split_pkg::ADDR_W-1:0]   ar_addr_i,
  input  logic [burst_split_pkg::LEN_W-1:0]    ar_len_i,
  input  logic [burst_split_pkg::SIZE_W-1:0]   ar_size_i,
  input  logic [burst_split_pkg::BURST_W-1:0]  ar_burst_i,
  // Upstream R
  output logic                                 r_valid_o,
  input  logic                                 r_ready_i,
  output logic [burst_split_pkg::ID_W-1:0]     r_id_o,
  output logic [burst_split_pkg::DATA_W-1:0]   r_data_o,
  output logic [burst_split_pkg::RESP_W-1:0]   r_resp_o,
  output logic                                 r_last_o,
  // Downstream AR, every read is one beat
  output logic                                 m_ar_valid_o,
  input  logic                                 m_ar_ready_i,
  output logic [burst_split_pkg::ID_W-1:0]     m_ar_id_o,
  output logic [burst_split_pkg::ADDR_W-1:0]   m_ar_addr_o,
  output logic [burst_split_pkg::SIZE_W-1:0]   m_ar_size_o,
  output logic [burst_split_pkg::BURST_W-1:0]  m_ar_burst_o,
  // Downstream R
  input  logic                                 m_r_valid_i,
  output logic                                 m_r_ready_o,
  input  logic [burst_split_pkg::ID_W-1:0]     m_r_id_i,
  input  logic [burst_split_pkg::DATA_W-1:0]   m_r_data_i,
  input  logic [burst_split_pkg::RESP_W-1:0]   m_r_resp_i
);

  logic                              alloc_req;
  logic                              alloc_gnt;
  logic [burst_split_pkg::ID_W-1:0]  alloc_id;
  logic [burst_split_pkg::LEN_W-1:0] alloc_len;
  logic [burst_split_pkg::ID_W-1:0]  rd_id;
  logic                              rd_dec;
  logic                              r_gnt;
  logic [burst_split_pkg::LEN_W-1:0] rem_len;

  ar_splitter u_ar_splitter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .ar_id_i      (ar_id_i),
    .ar_addr_i    (ar_addr_i),
    .ar_len_i     (ar_len_i),
    .ar_size_i    (ar_size_i),
    .ar_burst_i   (ar_burst_i),
    .m_ar_valid_o (m_ar_valid_o),
    .m_ar_ready_i (m_ar_ready_i),
    .m_ar_id_o    (m_ar_id_o),
    .m_ar_addr_o  (m_ar_addr_o),
    .m_ar_size_o  (m_ar_size_o),
    .m_ar_burst_o (m_ar_burst_o),
    .alloc_req_o  (alloc_req),
    .alloc_gnt_i  (alloc_gnt),
    .alloc_id_o   (alloc_id),
    .alloc_len_o  (alloc_len)
  );

  len_tracker u_len_tracker (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .alloc_req_i (alloc_req),
    .alloc_gnt_o (alloc_gnt),
    .alloc_id_i  (alloc_id),
    .alloc_len_i (alloc_len),
    .rd_id_i     (rd_id),
    .rd_dec_i    (rd_dec),
    .r_gnt_o     (r_gnt),
    .rem_len_o   (rem_len)
  );

  r_last_gen u_r_last_gen (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .m_r_id_i    (m_r_id_i),
    .m_r_data_i  (m_r_data_i),
    .m_r_resp_i  (m_r_resp_i),
    .r_valid_o   (r_valid_o),
    .r_ready_i   (r_ready_i),
    .r_id_o      (r_id_o),
    .r_data_o    (r_data_o),
    .r_resp_o    (r_resp_o),
    .r_last_o    (r_last_o),
    .rd_id_o     (rd_id),
    .rd_dec_o    (rd_dec),
    .r_gnt_i     (r_gnt),
    .rem_len_i   (rem_len)
  );

endmodule

/* sim/tb_read_slave.sv */
// Downstream single-beat read responder for the burst splitter testbench
// Random AR stalls from the testbench and an in-order response FIFO
`timescale 1ns/100ps

module tb_read_slave (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               stall_i,
  // Single-beat AR without a length field
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  input  logic [burst_split_pkg::ID_W-1:0]   ar_id_i,
  input  logic [burst_split_pkg::ADDR_W-1:0] ar_addr_i,
  // R channel
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output logic [burst_split_pkg::ID_W-1:0]   r_id_o,
  output logic [burst_split_pkg::DATA_W-1:0] r_data_o,
  output logic [burst_split_pkg::RESP_W-1:0] r_resp_o
);

  localparam int DEPTH = 16;

  logic [burst_split_pkg::ID_W-1:0]   id_mem   [DEPTH];
  logic [burst_split_pkg::DATA_W-1:0] data_mem [DEPTH];
  logic [3:0]                         wr_ptr;
  logic [3:0]                         rd_ptr;
  logic [4:0]                         count;
  logic                               push;
  logic                               pop;

  assign ar_ready_o = !stall_i && (count < 5'(DEPTH));
  assign r_valid_o  = (count != '0);
  assign r_id_o     = id_mem[rd_ptr];
  assign r_data_o   = data_mem[rd_ptr];
  assign r_resp_o   = 2'b00;

  assign push = ar_valid_i && ar_ready_o;
  assign pop  = r_valid_o && r_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        // Data is the scrambled address with the ID mixed into the low nibble
        id_mem[wr_ptr]   <= ar_id_i;
        data_mem[wr_ptr] <= (ar_addr_i ^ 32'h5a5a_0000) ^ {28'h0, ar_id_i};
        wr_ptr           <= wr_ptr + 4'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 4'd1;
      end
      count <= count + 5'(push) - 5'(pop);
    end
  end

endmodule

/* sim/tb_burst_splitter.sv */
// Testbench for the read-path burst splitter
// Clock, reset, LFSR stimulus, reference model, checker and report
`timescale 1ns/100ps

module tb_burst_splitter;

  localparam int TIMEOUT_CYCLES = 5000;
  localparam logic [31:0] SEED = 32'hbf32_e393;

  logic        clk_i;
  logic        rst_i;
  logic        ar_valid_i;
  logic        ar_ready_o;
  logic [3:0]  ar_id_i;
  logic [31:0] ar_addr_i;
  logic [7:0]  ar_len_i;
  logic [2:0]  ar_size_i;
  logic [1:0]  ar_burst_i;
  logic        r_valid_o;
  logic        r_ready_i;
  logic [3:0]  r_id_o;
  logic [31:0] r_data_o;
  logic [1:0]  r_resp_o;
  logic        r_last_o;
  logic        m_ar_valid;
  logic        m_ar_ready;
  logic [3:0]  m_ar_id;
  logic [31:0] m_ar_addr;
  logic [2:0]  m_ar_size;
  logic [1:0]  m_ar_burst;
  logic        m_r_valid;
  logic        m_r_ready;
  logic [3:0]  m_r_id;
  logic [31:0] m_r_data;
  logic [1:0]  m_r_resp;

  logic        slave_stall;
  logic        ar_stall_en;
  int          r_mode;
  logic [31:0] stim_lfsr;
  logic [31:0] stall_lfsr;
  logic [31:0] stall_bits;
  logic [31:0] bits;
  int          errors;
  int          checks;
  int          tests;
  int          err_start;

  // Burst under construction
  logic [3:0]  b_id;
  logic [31:0] b_addr;
  logic [7:0]  b_len;
  logic [2:0]  b_size;
  logic [1:0]  b_burst;

  // Expected beats in issue order
  logic [31:0] exp_ar_addr_q  [$];
  logic [3:0]  exp_ar_id_q    [$];
  logic [2:0]  exp_ar_size_q  [$];
  logic [1:0]  exp_ar_burst_q [$];
  logic [31:0] exp_r_data_q   [$];
  logic [3:0]  exp_r_id_q     [$];
  logic        exp_r_last_q   [$];
  logic [31:0] e_addr;
  logic [3:0]  e_id;
  logic [2:0]  e_size;
  logic [1:0]  e_burst;
  logic [31:0] e_data;
  logic        e_last;

  burst_splitter_top dut0 (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .ar_valid_i   (ar_valid_i),
    .ar_ready_o   (ar_ready_o),
    .ar_id_i      (ar_id_i),
    .ar_addr_i    (ar_addr_i),
    .ar_len_i     (ar_len_i),
    .ar_size_i    (ar_size_i),
    .ar_burst_i   (ar_burst_i),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .r_id_o       (r_id_o),
    .r_data_o     (r_data_o),
    .r_resp_o     (r_resp_o),
    .r_last_o     (r_last_o),
    .m_ar_valid_o (m_ar_valid),
    .m_ar_ready_i (m_ar_ready),
    .m_ar_id_o    (m_ar_id),
    .m_ar_addr_o  (m_ar_addr),
    .m_ar_size_o  (m_ar_size),
    .m_ar_burst_o (m_ar_burst),
    .m_r_valid_i  (m_r_valid),
    .m_r_ready_o  (m_r_ready),
    .m_r_id_i     (m_r_id),
    .m_r_data_i   (m_r_data),
    .m_r_resp_i   (m_r_resp)
  );

  tb_read_slave u_slave (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .stall_i    (slave_stall),
    .ar_valid_i (m_ar_valid),
    .ar_ready_o (m_ar_ready),
    .ar_id_i    (m_ar_id),
    .ar_addr_i  (m_ar_addr),
    .r_valid_o  (m_r_valid),
    .r_ready_i  (m_r_ready),
    .r_id_o     (m_r_id),
    .r_data_o   (m_r_data),
    .r_resp_o   (m_r_resp)
  );

  always #50 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // Random numbers and reference model
  // ------------------------------------------------------------
  function automatic logic [31:0] next_lfsr(input logic [31:0] st);
    if (st[0]) begin
      return (st >> 1) ^ 32'ha300_0000;
    end
    return st >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i] = st[0];
      st     = next_lfsr(st);
    end
  endtask

  function automatic logic [31:0] expected_addr(input logic [31:0] start, input logic [2:0] size,
                                                input logic [1:0] burst, input int k);
    if (burst == burst_split_pkg::BURST_INCR) begin
      return start + (32'(k) << size);
    end
    return start;
  endfunction

  function automatic logic [31:0] expected_data(input logic [31:0] addr, input logic [3:0] id);
    return (addr ^ 32'h5a5a_0000) ^ {28'h0, id};
  endfunction

  // ------------------------------------------------------------
  // Stall driver
  // ------------------------------------------------------------
  always @(posedge clk_i) begin
    #10;
    take_bits(stall_lfsr, 2, stall_bits);
    slave_stall = ar_stall_en && (stall_bits[1:0] == 2'd0);
    take_bits(stall_lfsr, 2, stall_bits);
    if (r_mode == 0) begin
      r_ready_i = 1'b1;
    end else if (r_mode == 2) begin
      r_ready_i = 1'b0;
    end else begin
      r_ready_i = (stall_bits[1:0] != 2'd0);
    end
  end

  // ------------------------------------------------------------
  // Checker sampling in the middle of the cycle
  // ------------------------------------------------------------
  always @(negedge clk_i) begin
    if (!rst_i && m_ar_valid && m_ar_ready) begin
      if (exp_ar_addr_q.size() == 0) begin
        $display("Downstream read at %0t arrived with no beat expected", $time);
        errors++;
      end else begin
        e_addr  = exp_ar_addr_q.pop_front();
        e_id    = exp_ar_id_q.pop_front();
        e_size  = exp_ar_size_q.pop_front();
        e_burst = exp_ar_burst_q.pop_front();
        checks++;
        assert (m_ar_addr == e_addr && m_ar_id == e_id && m_ar_size == e_size &&
                m_ar_burst == e_burst) else begin
          $display("CHECK FAILED at %0t: AR %0h %08h %0d %0d, expected %0h %08h %0d %0d",
                   $time, m_ar_id, m_ar_addr, m_ar_size, m_ar_burst,
                   e_id, e_addr, e_size, e_burst);
          errors++;
        end
      end
    end
    if (!rst_i && r_valid_o && r_ready_i) begin
      if (exp_r_data_q.size() == 0) begin
        $display("Upstream R beat at %0t arrived with no beat expected", $time);
        errors++;
      end else begin
        e_data = exp_r_data_q.pop_front();
        e_id   = exp_r_id_q.pop_front();
        e_last = exp_r_last_q.pop_front();
        checks++;
        assert (r_data_o == e_data && r_id_o == e_id && r_last_o == e_last &&
                r_resp_o == 2'b00) else begin
          $display("CHECK FAILED at %0t: R id %0h data %08h last %0b, expected %0h %08h %0b",
                   $time, r_id_o, r_data_o, r_last_o, e_id, e_data, e_last);
          errors++;
        end
      end
    end
    // A downstream beat is taken exactly when it goes up
    if (!rst_i) begin
      checks++;
      assert (m_r_ready == (r_valid_o && r_ready_i)) else begin
        $display("CHECK FAILED at %0t: m_r_ready_o %0b, expected %0b",
                 $time, m_r_ready, r_valid_o && r_ready_i);
        errors++;
      end
    end
  end

  // ------------------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------------------
  task automatic stop_on_timeout(input string what);
    $display("Timeout while %s at %0t", what, $time);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // Stall modes change at the falling edge and take effect at the next drive
  task automatic set_stall_mode(input int mode, input logic ar_en);
    @(negedge clk_i);
    r_mode      = mode;
    ar_stall_en = ar_en;
    @(posedge clk_i);
    #10;
  endtask

  // Burst type select with 0 for FIXED, 1 for INCR and 2 at random
  task automatic gen_burst(input int len_lo, input int len_hi, input int sel);
    take_bits(stim_lfsr, 3, bits);
    b_len = 8'(len_lo + (int'(bits[2:0]) % (len_hi - len_lo + 1)));
    take_bits(stim_lfsr, 2, bits);
    b_id = {2'b00, bits[1:0]};
    take_bits(stim_lfsr, 2, bits);
    b_size = (bits[1:0] == 2'd3) ? 3'd2 : {1'b0, bits[1:0]};
    take_bits(stim_lfsr, 1, bits);
    b_burst = (sel == 2) ? {1'b0, bits[0]} : 2'(sel);
    take_bits(stim_lfsr, 16, bits);
    b_addr = {12'h000, bits[15:0], 4'h0};
  endtask

  task automatic push_expect();
    for (int k = 0; k <= int'(b_len); k++) begin
      e_addr = expected_addr(b_addr, b_size, b_burst, k);
      exp_ar_addr_q.push_back(e_addr);
      exp_ar_id_q.push_back(b_id);
      exp_ar_size_q.push_back(b_size);
      exp_ar_burst_q.push_back(b_burst);
      exp_r_data_q.push_back(expected_data(e_addr, b_id));
      exp_r_id_q.push_back(b_id);
      exp_r_last_q.push_back(k == int'(b_len));
    end
  endtask

  task automatic drive_ar();
    ar_valid_i = 1'b1;
    ar_id_i    = b_id;
    ar_addr_i  = b_addr;
    ar_len_i   = b_len;
    ar_size_i  = b_size;
    ar_burst_i = b_burst;
  endtask

  task automatic wait_ar_accept();
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!ar_ready_o) begin
      cnt++;
      if (cnt > TIMEOUT_CYCLES) begin
        stop_on_timeout("waiting for AR acceptance");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
    ar_valid_i = 1'b0;
  endtask

  task automatic send_burst(input int len_lo, input int len_hi, input int sel);
    gen_burst(len_lo, len_hi, sel);
    push_expect();
    drive_ar();
    wait_ar_accept();
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_ar_addr_q.size() != 0 || exp_r_data_q.size() != 0) begin
      @(posedge clk_i);
      cnt++;
      if (cnt > TIMEOUT_CYCLES) begin
        stop_on_timeout("waiting for outstanding beats");
      end
    end
    #10;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %s (%0d errors)", tests, name,
             (errors == err_start) ? "ok" : "errors", errors - err_start);
    err_start = errors;
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    ar_valid_i  = 1'b0;
    ar_id_i     = '0;
    ar_addr_i   = '0;
    ar_len_i    = '0;
    ar_size_i   = '0;
    ar_burst_i  = '0;
    r_ready_i   = 1'b0;
    slave_stall = 1'b0;
    ar_stall_en = 1'b0;
    r_mode      = 0;
    stim_lfsr   = SEED;
    stall_lfsr  = SEED;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    err_start   = 0;
    repeat (4) @(posedge clk_i);
    #10;
    rst_i = 1'b0;

    repeat (4) send_burst(0, 0, 2);
    wait_drain();
    finish_test("length zero reads");

    repeat (6) send_burst(1, 7, 1);
    wait_drain();
    finish_test("INCR bursts");

    repeat (6) send_burst(1, 7, 0);
    wait_drain();
    finish_test("FIXED bursts");

    repeat (10) send_burst(0, 7, 2);
    wait_drain();
    finish_test("data and last flags");

    // Fill the table while R is held, then check that AR is held off
    set_stall_mode(2, 1'b0);
    repeat (burst_split_pkg::MAX_TXNS) send_burst(1, 3, 2);
    gen_burst(1, 3, 2);
    push_expect();
    drive_ar();
    repeat (10) begin
      @(negedge clk_i);
      checks++;
      assert (!ar_ready_o) else begin
        $display("CHECK FAILED at %0t: ar_ready_o high with the tracker full", $time);
        errors++;
      end
    end
    r_mode = 0;
    wait_ar_accept();
    wait_drain();
    finish_test("full tracker");

    set_stall_mode(1, 1'b1);
    repeat (40) send_burst(0, 7, 2);
    wait_drain();
    finish_test("random stalls");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* burst_splitter.f */
verilog/burst_split_pkg.sv
verilog/ar_splitter.sv
verilog/len_tracker.sv
verilog/r_last_gen.sv
verilog/burst_splitter_top.sv
sim/tb_read_slave.sv
sim/tb_burst_splitter.sv

/* Makefile */
# Verilator build for the read-path burst splitter

VERILATOR ?= verilator
TOP       ?= tb_burst_splitter
RTL_TOP   ?= burst_splitter_top
FILELIST  ?= burst_splitter.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) \
		verilog/burst_split_pkg.sv verilog/ar_splitter.sv verilog/len_tracker.sv \
		verilog/r_last_gen.sv verilog/burst_splitter_top.sv

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
